// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_fetch
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire fetch_pkg::addr_t       pc_if1,
    input  wire fetch_pkg::btb_update_t update,
    output fetch_pkg::addr_t            pc_predict
);

    import fetch_pkg::*;

    // Entry arrays, direct mapped on PC bits 4:2
    logic [BTB_ENTRIES-1:0] entry_valid;
    logic [BTB_TAG_W-1:0] entry_tag [BTB_ENTRIES];
    addr_t entry_target [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic hit;

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////
    assign rd_idx = pc_if1[BTB_IDX_W+1:2];
    assign hit = entry_valid[rd_idx] & (entry_tag[rd_idx] == pc_if1[31:BTB_IDX_W+2]);

    // Fall through to the next word on a miss
    assign pc_predict = hit ? entry_target[rd_idx] : pc_if1 + 32'd4;

    ////////////////////////////////////////////////////////////
    // Update from the back end
    ////////////////////////////////////////////////////////////
    assign wr_idx = update.pc[BTB_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            entry_valid <= '0;
        end else if (update.valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target only, valid bit above
    always_ff @(posedge clk) begin
        if (update.valid) begin
            entry_tag[wr_idx] <= update.pc[31:BTB_IDX_W+2];
            entry_target[wr_idx] <= update.target;
        end
    end

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and constants
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam logic [7:0] ECODE_ADEF = 8'h88;
    localparam int MISS_CYCLES = 3;
    localparam int QUEUE_DEPTH = 4;
    localparam int BTB_ENTRIES = 8;
    localparam int ICACHE_LINES = 4;

    // Derived index and tag widths, word aligned
    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W = 30 - BTB_IDX_W;
    localparam int ICACHE_IDX_W = $clog2(ICACHE_LINES);
    localparam int ICACHE_TAG_W = 30 - ICACHE_IDX_W;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int MISS_CNT_W = $clog2(MISS_CYCLES + 1);

    // Opcodes used by the ROM and the predecoder
    localparam logic [5:0] OP_B = 6'b010100;
    localparam logic [9:0] OP_ANDI = 10'b0000001101;
    // B +16 bytes, offset counted in words
    localparam logic [25:0] ROM_B_OFFS = 26'd4;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    // Bit 7 valid, bits 6:0 exception code
    typedef logic [7:0] ecode_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        ecode_t ecode;
    } fetch_entry_t;

    // Listed from highest to lowest priority
    typedef struct packed {
        logic era_en;
        addr_t era_pc;
        logic eentry_en;
        addr_t eentry_pc;
        logic csr_flush;
        addr_t csr_pc;
        logic mem_br;
        addr_t br_pc;
    } backend_redirect_t;

    typedef struct packed {
        logic flush;
        addr_t addr;
    } cacop_req_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        addr_t target;
    } btb_update_t;

    typedef enum logic {
        LOOKUP,
        FILL
    } icache_state_t;

    ////////////////////////////////////////////////////////////
    // Instruction ROM contents
    ////////////////////////////////////////////////////////////
    // Last word of every 128-byte block jumps ahead 16 bytes
    function automatic inst_t rom_word(input addr_t addr);
        inst_t word;
        if (addr[6:2] == 5'h1f) begin
            // LoongArch B layout, offs[15:0] above offs[25:16]
            word = {OP_B, ROM_B_OFFS[15:0], ROM_B_OFFS[25:16]};
        end else begin
            // ANDI with the word index in the register fields
            word = {OP_ANDI, 12'h000, addr[11:2]};
        end
        return word;
    endfunction

endpackage

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire logic                         clk,
    input  wire logic                         rstn,
    input  wire fetch_pkg::backend_redirect_t redirect,
    input  wire fetch_pkg::cacop_req_t        cacop,
    input  wire fetch_pkg::btb_update_t       btb_update,
    input  wire logic                         deq_ready,
    output logic                              deq_valid,
    output fetch_pkg::fetch_entry_t           deq_entry
);

    import fetch_pkg::*;

    // IF1 side
    addr_t pc_if1;
    addr_t pc_predict;
    ecode_t ecode;
    logic is_valid;
    logic stall_icache;
    logic stall_full;

    // IF2 side
    logic if2_valid;
    fetch_entry_t if2_entry;
    addr_t if2_pred;
    logic br_predecoder;
    addr_t pc_predecoder;

    logic flush;

    // Any back-end redirect or cache op clears IF2 and the queue
    assign flush = redirect.era_en | redirect.eentry_en | redirect.csr_flush |
                   redirect.mem_br | cacop.flush;

    ////////////////////////////////////////////////////////////
    // IF1
    ////////////////////////////////////////////////////////////
    pc_select u_pc_select (
        .clk           (clk),
        .rstn          (rstn),
        .pc_predict    (pc_predict),
        .redirect      (redirect),
        .cacop         (cacop),
        .br_predecoder (br_predecoder),
        .pc_predecoder (pc_predecoder),
        .stall_icache  (stall_icache),
        .stall_full    (stall_full),
        .pc_if1        (pc_if1),
        .ecode         (ecode),
        .is_valid      (is_valid)
    );

    branch_target_buffer u_btb (
        .clk        (clk),
        .rstn       (rstn),
        .pc_if1     (pc_if1),
        .update     (btb_update),
        .pc_predict (pc_predict)
    );

    // Cache lookup in IF1, result registered into IF2
    icache_model u_icache (
        .clk          (clk),
        .rstn         (rstn),
        .pc_if1       (pc_if1),
        .is_valid     (is_valid),
        .pc_predict   (pc_predict),
        .cacop        (cacop),
        .flush        (flush),
        .ecode        (ecode),
        .stall_icache (stall_icache),
        .if2_valid    (if2_valid),
        .if2_entry    (if2_entry),
        .if2_pred     (if2_pred)
    );

    ////////////////////////////////////////////////////////////
    // IF2 and queue
    ////////////////////////////////////////////////////////////
    predecoder u_predecoder (
        .if2_valid     (if2_valid),
        .if2_entry     (if2_entry),
        .if2_pred      (if2_pred),
        .br_predecoder (br_predecoder),
        .pc_predecoder (pc_predecoder)
    );

    inst_queue u_inst_queue (
        .clk        (clk),
        .rstn       (rstn),
        .push       (if2_valid),
        .push_entry (if2_entry),
        .flush      (flush),
        .deq_ready  (deq_ready),
        .deq_valid  (deq_valid),
        .deq_entry  (deq_entry),
        .stall_full (stall_full)
    );

endmodule

`default_nettype wire

// File: icache_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_model (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire fetch_pkg::addr_t      pc_if1,
    input  wire logic                  is_valid,
    input  wire fetch_pkg::addr_t      pc_predict,
    input  wire fetch_pkg::cacop_req_t cacop,
    input  wire logic                  flush,
    input  wire fetch_pkg::ecode_t     ecode,
    output logic                       stall_icache,
    output logic                       if2_valid,
    output fetch_pkg::fetch_entry_t    if2_entry,
    output fetch_pkg::addr_t           if2_pred
);

    import fetch_pkg::*;

    icache_state_t state;
    logic [MISS_CNT_W-1:0] fill_cnt;
    // Address of the line being filled
    addr_t fill_addr;
    // Lookups start one cycle after reset release
    logic lookup_en;

    // One word per line
    logic [ICACHE_LINES-1:0] line_valid;
    logic [ICACHE_TAG_W-1:0] line_tag [ICACHE_LINES];

    logic [ICACHE_IDX_W-1:0] idx;
    logic [ICACHE_IDX_W-1:0] fill_idx;
    logic [ICACHE_IDX_W-1:0] cacop_idx;
    logic hit;
    logic miss;
    logic fill_done;
    logic cacop_hit;

    ////////////////////////////////////////////////////////////
    // Tag compare
    ////////////////////////////////////////////////////////////
    assign idx = pc_if1[ICACHE_IDX_W+1:2];
    assign fill_idx = fill_addr[ICACHE_IDX_W+1:2];
    assign cacop_idx = cacop.addr[ICACHE_IDX_W+1:2];

    assign hit = line_valid[idx] & (line_tag[idx] == pc_if1[31:ICACHE_IDX_W+2]);
    assign miss = lookup_en & (state == LOOKUP) & ~hit;
    assign fill_done = (state == FILL) & (fill_cnt == '0);
    assign cacop_hit = cacop.flush & line_valid[cacop_idx] &
                       (line_tag[cacop_idx] == cacop.addr[31:ICACHE_IDX_W+2]);

    // Miss cycle and whole fill hold IF1
    assign stall_icache = (state == FILL) | miss;

    ////////////////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= LOOKUP;
            fill_cnt <= '0;
            lookup_en <= 1'b0;
        end else begin
            lookup_en <= 1'b1;
            case (state)
                LOOKUP: begin
                    // No fill for a PC that is being abandoned
                    if (miss && !flush) begin
                        state <= FILL;
                        fill_cnt <= MISS_CNT_W'(MISS_CYCLES - 1);
                    end
                end
                FILL: begin
                    if (fill_cnt == '0) begin
                        state <= LOOKUP;
                    end else begin
                        fill_cnt <= fill_cnt - 1'b1;
                    end
                end
                default: state <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss && !flush) begin
            fill_addr <= pc_if1;
        end
    end

    // Valid bits, invalidate wins over a fill on the same line
    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_valid <= '0;
        end else begin
            if (fill_done) begin
                line_valid[fill_idx] <= 1'b1;
            end
            if (cacop_hit) begin
                line_valid[cacop_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            line_tag[fill_idx] <= fill_addr[31:ICACHE_IDX_W+2];
        end
    end

    ////////////////////////////////////////////////////////////
    // IF2 register
    ////////////////////////////////////////////////////////////
    // Valid for one cycle per fetched word
    always_ff @(posedge clk) begin
        if (!rstn) begin
            if2_valid <= 1'b0;
        end else begin
            if2_valid <= is_valid & hit & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (is_valid && hit) begin
            if2_entry.pc <= pc_if1;
            if2_entry.inst <= rom_word(pc_if1);
            if2_entry.ecode <= ecode;
            // Prediction the word was fetched with
            if2_pred <= pc_predict;
        end
    end

endmodule

`default_nettype wire

// File: inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    push,
    input  wire fetch_pkg::fetch_entry_t push_entry,
    input  wire logic                    flush,
    input  wire logic                    deq_ready,
    output logic                         deq_valid,
    output fetch_pkg::fetch_entry_t      deq_entry,
    output logic                         stall_full
);

    import fetch_pkg::*;

    fetch_entry_t mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////
    assign deq_valid = (count != '0);
    assign deq_entry = mem[rd_ptr];

    // One slot kept free for the word already in IF2
    assign stall_full = (count >= QUEUE_CNT_W'(QUEUE_DEPTH - 1));

    assign do_push = push & ~flush;
    assign do_pop = deq_valid & deq_ready & ~flush;

    ////////////////////////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

endmodule

`default_nettype wire

// File: pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module pc_select (
    input  wire logic                         clk,
    input  wire logic                         rstn,
    input  wire fetch_pkg::addr_t             pc_predict,
    input  wire fetch_pkg::backend_redirect_t redirect,
    input  wire fetch_pkg::cacop_req_t        cacop,
    input  wire logic                         br_predecoder,
    input  wire fetch_pkg::addr_t             pc_predecoder,
    input  wire logic                         stall_icache,
    input  wire logic                         stall_full,
    output fetch_pkg::addr_t                  pc_if1,
    output fetch_pkg::ecode_t                 ecode,
    output logic                              is_valid
);

    import fetch_pkg::*;

    logic stall;
    logic redirect_any;
    // Goes high one cycle after reset release
    logic valid_q;

    assign stall = stall_icache | stall_full;

    // Back-end redirects and cache-op flush as in the top-level flush
    assign redirect_any = redirect.era_en | redirect.eentry_en | redirect.csr_flush |
                          cacop.flush | redirect.mem_br;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // Word in IF1 is dropped on any stall, redirect or correction
    assign is_valid = valid_q & ~stall & ~redirect_any & ~br_predecoder;

    ////////////////////////////////////////////////////////////
    // Fetch PC by fixed priority
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if1 <= RESET_PC;
        end else if (redirect.era_en) begin
            pc_if1 <= redirect.era_pc;
        end else if (redirect.eentry_en) begin
            pc_if1 <= redirect.eentry_pc;
        end else if (redirect.csr_flush) begin
            pc_if1 <= redirect.csr_pc;
        end else if (cacop.flush) begin
            pc_if1 <= cacop.addr;
        end else if (redirect.mem_br) begin
            pc_if1 <= redirect.br_pc;
        end else if (br_predecoder) begin
            pc_if1 <= pc_predecoder;
        end else if (valid_q && !stall) begin
            pc_if1 <= pc_predict;
        end
        // Stall and the first cycle after reset hold the PC
    end

    // Address fetch error on a word-misaligned PC
    assign ecode = (pc_if1[1:0] != 2'b00) ? ECODE_ADEF : ecode_t'(0);

endmodule

`default_nettype wire

// File: predecoder.sv
`timescale 1ns/1ps
`default_nettype none

module predecoder (
    input  wire logic                    if2_valid,
    input  wire fetch_pkg::fetch_entry_t if2_entry,
    input  wire fetch_pkg::addr_t        if2_pred,
    output logic                         br_predecoder,
    output fetch_pkg::addr_t             pc_predecoder
);

    import fetch_pkg::*;

    logic is_branch;
    // Word offset, reassembled from the split B fields
    logic [25:0] offs;
    addr_t br_target;
    addr_t seq_pc;

    ////////////////////////////////////////////////////////////
    // Direct branch decode
    ////////////////////////////////////////////////////////////
    assign is_branch = (if2_entry.inst[31:26] == OP_B);
    assign offs = {if2_entry.inst[9:0], if2_entry.inst[25:10]};

    // Sign extend and scale words to bytes
    assign br_target = if2_entry.pc + {{4{offs[25]}}, offs, 2'b00};
    assign seq_pc = if2_entry.pc + 32'd4;

    ////////////////////////////////////////////////////////////
    // Correction
    ////////////////////////////////////////////////////////////
    // Covers missed branches and stale BTB hits on plain words
    assign pc_predecoder = is_branch ? br_target : seq_pc;
    assign br_predecoder = if2_valid & (pc_predecoder != if2_pred);

endmodule

`default_nettype wire

// File: sources.f
fetch_pkg.sv
pc_select.sv
branch_target_buffer.sv
icache_model.sv
predecoder.sv
inst_queue.sv
fetch_top.sv
tb_fetch.sv

// File: tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    import fetch_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int NUM_ROWS = 9;

    typedef enum int {
        ACT_NONE,
        ACT_ERA,
        ACT_EENTRY,
        ACT_CSR,
        ACT_MEM_BR,
        ACT_CACOP,
        ACT_ERA_MEM_BR,
        ACT_BTB
    } action_t;

    // One stimulus row and its number of entries to check
    typedef struct {
        string name;
        action_t action;
        addr_t pc;
        bit rand_ready;
        int count;
    } row_t;

    logic clk;
    logic rstn;
    backend_redirect_t redirect;
    cacop_req_t cacop;
    btb_update_t btb_update;
    logic deq_ready;
    logic deq_valid;
    fetch_entry_t deq_entry;

    row_t rows [NUM_ROWS];
    int num_loaded;
    logic [31:0] lfsr;
    // Next PC the decode side should see
    addr_t exp_pc;

    fetch_top u_fetch_top (
        .clk        (clk),
        .rstn       (rstn),
        .redirect   (redirect),
        .cacop      (cacop),
        .btb_update (btb_update),
        .deq_ready  (deq_ready),
        .deq_valid  (deq_valid),
        .deq_entry  (deq_entry)
    );

    always #(CLK_HALF) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Galois LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // Last word of each 128-byte block branches 16 bytes ahead
    function automatic addr_t follow_pc(input addr_t pc);
        addr_t next;
        if (pc[6:2] == 5'h1f) begin
            next = pc + 32'd16;
        end else begin
            next = pc + 32'd4;
        end
        return next;
    endfunction

    // Address fetch error for any word-misaligned PC
    function automatic ecode_t expect_ecode(input addr_t pc);
        ecode_t code;
        code = (pc[1:0] != 2'b00) ? 8'h88 : 8'h00;
        return code;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: %s expected %h actual %h", test, field, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////
    task automatic add_row(input string name, input action_t action, input addr_t pc,
                           input bit rand_ready, input int count);
        rows[num_loaded].name = name;
        rows[num_loaded].action = action;
        rows[num_loaded].pc = pc;
        rows[num_loaded].rand_ready = rand_ready;
        rows[num_loaded].count = count;
        num_loaded++;
    endtask

    task automatic load_table();
        // Runs through the first block branch
        add_row("reset_seq", ACT_NONE, 32'h0, 1'b0, 40);
        // Era target wins over the branch target
        add_row("era_over_mem_br", ACT_ERA_MEM_BR, 32'h1c00_1000, 1'b0, 8);
        add_row("eentry", ACT_EENTRY, 32'h1c00_2040, 1'b0, 8);
        add_row("csr_flush", ACT_CSR, 32'h1c00_0f70, 1'b0, 12);
        add_row("mem_br_misaligned", ACT_MEM_BR, 32'h1c00_0102, 1'b0, 8);
        add_row("mem_br_aligned", ACT_MEM_BR, 32'h1c00_0200, 1'b0, 6);
        // Trains a PC a few words ahead of the fetch front
        add_row("btb_wrong_target", ACT_BTB, 32'h1c00_0240, 1'b1, 24);
        add_row("rand_ready", ACT_NONE, 32'h0, 1'b1, 48);
        add_row("cacop_refetch", ACT_CACOP, 32'h1c00_0340, 1'b1, 20);
    endtask

    // One-cycle strobe for the row's back-end event
    task automatic apply_action(input row_t row);
        redirect = '0;
        cacop = '0;
        btb_update = '0;
        case (row.action)
            ACT_ERA: begin
                redirect.era_en = 1'b1;
                redirect.era_pc = row.pc;
            end
            ACT_EENTRY: begin
                redirect.eentry_en = 1'b1;
                redirect.eentry_pc = row.pc;
            end
            ACT_CSR: begin
                redirect.csr_flush = 1'b1;
                redirect.csr_pc = row.pc;
            end
            ACT_MEM_BR: begin
                redirect.mem_br = 1'b1;
                redirect.br_pc = row.pc;
            end
            ACT_CACOP: begin
                cacop.flush = 1'b1;
                cacop.addr = row.pc;
            end
            ACT_ERA_MEM_BR: begin
                redirect.era_en = 1'b1;
                redirect.era_pc = row.pc;
                redirect.mem_br = 1'b1;
                redirect.br_pc = row.pc + 32'h100;
            end
            ACT_BTB: begin
                // Wrong target that the predecoder repairs
                btb_update.valid = 1'b1;
                btb_update.pc = row.pc;
                btb_update.target = row.pc + 32'h80;
            end
            default: begin
            end
        endcase
        if (row.action != ACT_NONE) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            redirect = '0;
            cacop = '0;
            btb_update = '0;
        end
        // Stream restarts at the redirect target
        if (row.action != ACT_NONE && row.action != ACT_BTB) begin
            exp_pc = row.pc;
        end
    endtask

    // Outputs sampled just after the drive point with one pop per edge
    task automatic run_row(input row_t row);
        int got;
        logic ready_bit;
        got = 0;
        deq_ready = 1'b0;
        apply_action(row);
        while (got < row.count) begin
            if (row.rand_ready) begin
                lfsr = lfsr_step(lfsr);
                ready_bit = lfsr[0];
            end else begin
                ready_bit = 1'b1;
            end
            deq_ready = ready_bit;
            if (deq_valid && ready_bit) begin
                check_value(row.name, "pc", exp_pc, deq_entry.pc);
                check_value(row.name, "inst", rom_word(exp_pc), deq_entry.inst);
                check_value(row.name, "ecode", 32'(expect_ecode(exp_pc)),
                            32'(deq_entry.ecode));
                exp_pc = follow_pc(exp_pc);
                got++;
            end
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        deq_ready = 1'b0;
    endtask

    task automatic run_watchdog();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += rows[i].count;
        end
        repeat (RESET_CYCLES + total * CYCLES_PER_ENTRY) @(posedge clk);
        $display("Timeout: decode stream did not deliver all %0d entries", total);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        redirect = '0;
        cacop = '0;
        btb_update = '0;
        deq_ready = 1'b0;
        num_loaded = 0;
        lfsr = 32'h6c3aa1f1;
        exp_pc = RESET_PC;
        load_table();
        fork
            run_watchdog();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rstn = 1'b1;
        // Queue comes out of reset empty
        check_value("reset", "deq_valid", 32'd0, 32'(deq_valid));
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
